// File: logic/argmin_defs.svh
`ifndef ARGMIN_DEFS_SVH
`define ARGMIN_DEFS_SVH

// Width of one floating-point lane word.
`define ARGMIN_FLOAT_W 32

// Number of lanes in one input beat. Must be a power of two.
`define ARGMIN_LANES 16

// Bits needed to name one lane, log2 of the lane count.
`define ARGMIN_IDX_W 4

`endif

// File: logic/float_pkg.sv
`default_nettype none

`include "argmin_defs.svh"

package float_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Single-precision word layout
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // IEEE-754 binary32 fields, most significant first.
  typedef struct packed {
    logic       sign;
    logic [7:0] exponent;  // Biased. All ones marks inf or NaN.
    logic [22:0] mantissa;
  } float_fields_t;

  // The same word seen two ways. The fields give NaN and zero detection,
  // the raw bits give the magnitude compare once the sign is dropped.
  typedef union packed {
    logic [`ARGMIN_FLOAT_W-1:0] raw;
    float_fields_t               fields;
  } float_word_u;

endpackage

`default_nettype wire

// File: logic/argmin_pkg.sv
`default_nettype none

`include "argmin_defs.svh"

package argmin_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Words carried by the tree
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One contender for the minimum. Every compare stage takes two of these
  // and passes the winner on unchanged.
  typedef struct packed {
    float_pkg::float_word_u    value;
    logic [`ARGMIN_IDX_W-1:0]  index;     // Lane the value came from.
    logic                      eligible;  // Tag bit of that lane.
  } candidate_t;

  // What leaves the unit for each input beat.
  typedef struct packed {
    logic                      found;  // Low when no lane was tagged.
    logic [`ARGMIN_IDX_W-1:0]  index;
    float_pkg::float_word_u    value;
  } argmin_result_t;

endpackage

`default_nettype wire

// File: logic/float_argmin.sv
`timescale 1ns/1ns
`default_nettype none

`include "argmin_defs.svh"

// Two-input compare stage of the argmin tree. Picks the smaller of two
// candidates and holds it in an output register with a valid/ready handshake.
module float_argmin (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  argmin_pkg::candidate_t s_axis_a_tdata,
  input  argmin_pkg::candidate_t s_axis_b_tdata,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  output argmin_pkg::candidate_t m_axis_result_tdata,
  output logic                   m_axis_result_tvalid,
  input  logic                   m_axis_result_tready
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Float helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Exponent all ones with a nonzero mantissa.
  function automatic logic is_nan(float_pkg::float_word_u w);
    return (w.fields.exponent == '1) && (w.fields.mantissa != '0);
  endfunction

  function automatic logic is_zero(float_pkg::float_word_u w);
    return (w.fields.exponent == '0) && (w.fields.mantissa == '0);
  endfunction

  // Strict a < b for two non-NaN words. Both zeros compare equal
  // whatever their signs.
  function automatic logic less_than(float_pkg::float_word_u a,
                                     float_pkg::float_word_u b);
    logic [`ARGMIN_FLOAT_W-2:0] mag_a;
    logic [`ARGMIN_FLOAT_W-2:0] mag_b;
    mag_a = a.raw[`ARGMIN_FLOAT_W-2:0];
    mag_b = b.raw[`ARGMIN_FLOAT_W-2:0];
    if (is_zero(a) && is_zero(b)) begin
      return 1'b0;
    end
    if (a.fields.sign != b.fields.sign) begin
      return a.fields.sign;  // The negative one is smaller.
    end
    // Same sign. For negatives the larger magnitude is the smaller value.
    if (a.fields.sign) begin
      return mag_a > mag_b;
    end
    return mag_a < mag_b;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Winner selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic                   a_nan;
  logic                   b_nan;
  logic                   pick_b;
  argmin_pkg::candidate_t winner;

  assign a_nan = is_nan(s_axis_a_tdata.value);
  assign b_nan = is_nan(s_axis_b_tdata.value);

  // Operand a always carries the lower lane numbers, so every tie keeps a.
  always_comb begin
    if (s_axis_a_tdata.eligible != s_axis_b_tdata.eligible) begin
      pick_b = s_axis_b_tdata.eligible;
    end else if (a_nan || b_nan) begin
      pick_b = a_nan && !b_nan;  // A NaN only wins against another NaN.
    end else begin
      pick_b = less_than(s_axis_b_tdata.value, s_axis_a_tdata.value);
    end
  end

  assign winner = pick_b ? s_axis_b_tdata : s_axis_a_tdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output register and handshake
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic                   result_valid;
  argmin_pkg::candidate_t result_data;
  logic                   in_xfer;

  // Room for a new beat if empty, or if the held one leaves on this edge.
  assign s_axis_tready = !result_valid || m_axis_result_tready;
  assign in_xfer       = s_axis_tvalid && s_axis_tready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (in_xfer) begin
      result_valid <= 1'b1;
    end else if (m_axis_result_tready) begin
      result_valid <= 1'b0;  // Drained with nothing behind it.
    end
  end

  // Loads only on a transfer, so a stalled stage keeps its word.
  always_ff @(posedge aclk) begin
    if (in_xfer) begin
      result_data <= winner;
    end
  end

  assign m_axis_result_tdata  = result_data;
  assign m_axis_result_tvalid = result_valid;

endmodule

`default_nettype wire

// File: logic/float_multi_argmin.sv
`timescale 1ns/1ns
`default_nettype none

`include "argmin_defs.svh"

// Argmin over all lanes of a beat. A binary tree of float_argmin stages,
// one register per level, so the result follows the input by the tree depth.
//
// Nodes are numbered as a heap. Stage k sits at node k and reads nodes 2k
// and 2k+1. Node 1 is the root, nodes LANES..2*LANES-1 are the lane
// candidates, with lane i at node LANES+i. Left to right order is kept,
// so operand a of every stage holds the lower lane numbers.
module float_multi_argmin (
  input  logic                                      aclk,
  input  logic                                      rst_n,
  input  float_pkg::float_word_u [`ARGMIN_LANES-1:0] s_axis_a_tdata,
  input  logic [`ARGMIN_LANES-1:0]                  tag,
  input  logic                                      s_axis_a_tvalid,
  output logic                                      s_axis_a_tready,
  output argmin_pkg::argmin_result_t                m_axis_result_tdata,
  output logic                                      m_axis_result_tvalid,
  input  logic                                      m_axis_result_tready
);

  localparam int LEVELS = `ARGMIN_IDX_W;
  localparam int NODES  = 2 * `ARGMIN_LANES - 1;
  localparam int STAGES = `ARGMIN_LANES - 1;

  argmin_pkg::candidate_t node_data  [1:NODES];
  logic                   node_valid [1:STAGES];  // Output valid of stage k.
  logic                   node_ready [1:STAGES];  // Ready seen by stage k output.
  logic                   stage_in_valid [1:STAGES];
  logic                   stage_in_ready [1:STAGES];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Lane candidates
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar i = 0; i < `ARGMIN_LANES; i++) begin : g_lane
    localparam int unsigned LANE = i;

    assign node_data[`ARGMIN_LANES + i] = argmin_pkg::candidate_t'{
      value:    s_axis_a_tdata[i],
      index:    LANE[`ARGMIN_IDX_W-1:0],
      eligible: tag[i]
    };
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Compare tree
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar lvl = 1; lvl <= LEVELS; lvl++) begin : g_level
    localparam int FIRST = 1 << (LEVELS - lvl);  // Lowest node on this level.

    for (genvar j = 0; j < FIRST; j++) begin : g_stage
      localparam int K = FIRST + j;

      // Level 1 reads the input beat directly. Higher levels need both
      // children, which always fill and drain on the same edges.
      if (lvl == 1) begin : g_in_leaf
        assign stage_in_valid[K] = s_axis_a_tvalid;
      end else begin : g_in_node
        assign stage_in_valid[K] = node_valid[2*K] && node_valid[2*K+1];
      end

      // Siblings share the parent's input ready. The root faces the port.
      if (K == 1) begin : g_out_root
        assign node_ready[K] = m_axis_result_tready;
      end else begin : g_out_node
        assign node_ready[K] = stage_in_ready[K/2];
      end

      float_argmin u_cmp (
        .aclk                 (aclk),
        .rst_n                (rst_n),
        .s_axis_a_tdata       (node_data[2*K]),
        .s_axis_b_tdata       (node_data[2*K+1]),
        .s_axis_tvalid        (stage_in_valid[K]),
        .s_axis_tready        (stage_in_ready[K]),
        .m_axis_result_tdata  (node_data[K]),
        .m_axis_result_tvalid (node_valid[K]),
        .m_axis_result_tready (node_ready[K])
      );
    end
  end

  // All first-level stages move in lockstep, so the leftmost one speaks
  // for the whole beat.
  assign s_axis_a_tready = stage_in_ready[`ARGMIN_LANES/2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // An ineligible root means no lane was tagged.
  assign m_axis_result_tdata = argmin_pkg::argmin_result_t'{
    found: node_data[1].eligible,
    index: node_data[1].index,
    value: node_data[1].value
  };
  assign m_axis_result_tvalid = node_valid[1];

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

// Free-running clock with a 4 ns period.
module tb_clock (
  output logic aclk
);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

endmodule

`default_nettype wire

// File: bench/tb_float_multi_argmin.sv
`timescale 1ns/1ns
`default_nettype none

`include "argmin_defs.svh"

module tb_float_multi_argmin;

  typedef float_pkg::float_word_u [`ARGMIN_LANES-1:0] lanes_t;
  typedef logic [`ARGMIN_LANES-1:0]                   tag_t;

  localparam int   WAIT_LIMIT   = 50;    // Cycles allowed for one handshake.
  localparam int   STREAM_LIMIT = 4000;
  localparam tag_t ALL_TAGS     = '1;

  logic                       aclk;
  logic                       rst_n;
  lanes_t                     lane_data;
  tag_t                       tag;
  logic                       in_valid;
  logic                       in_ready;
  argmin_pkg::argmin_result_t result;
  logic                       out_valid;
  logic                       out_ready;

  int                         error_count;
  int                         timeout_count;
  argmin_pkg::argmin_result_t expected_q[$];

  tb_clock u_clock (
    .aclk (aclk)
  );

  float_multi_argmin dut (
    .aclk                 (aclk),
    .rst_n                (rst_n),
    .s_axis_a_tdata       (lane_data),
    .tag                  (tag),
    .s_axis_a_tvalid      (in_valid),
    .s_axis_a_tready      (in_ready),
    .m_axis_result_tdata  (result),
    .m_axis_result_tvalid (out_valid),
    .m_axis_result_tready (out_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic nan_bits(float_pkg::float_word_u w);
    return (w.raw[30:23] == 8'hff) && (w.raw[22:0] != 23'd0);
  endfunction

  // Maps a non-NaN word onto an unsigned key in the same order.
  // Both zeros share one key.
  function automatic logic [31:0] order_key(float_pkg::float_word_u w);
    if (w.raw[30:0] == 31'd0) begin
      return 32'h8000_0000;
    end
    if (w.raw[31]) begin
      return ~w.raw;
    end
    return w.raw | 32'h8000_0000;
  endfunction

  // Scans the tagged lanes upward and keeps the first strict minimum.
  function automatic argmin_pkg::argmin_result_t model_argmin(lanes_t v, tag_t t);
    argmin_pkg::argmin_result_t r;
    int                         best;
    logic                       better;
    r    = '0;
    best = -1;
    for (int i = 0; i < `ARGMIN_LANES; i++) begin
      if (t[i]) begin
        if (best < 0) begin
          better = 1'b1;
        end else if (nan_bits(v[i])) begin
          better = 1'b0;
        end else if (nan_bits(v[best])) begin
          better = 1'b1;
        end else begin
          better = order_key(v[i]) < order_key(v[best]);
        end
        if (better) begin
          best = i;
        end
      end
    end
    if (best >= 0) begin
      r.found = 1'b1;
      r.index = best[`ARGMIN_IDX_W-1:0];
      r.value = v[best];
    end
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic float_pkg::float_word_u random_finite();
    float_pkg::float_word_u w;
    w.raw = $urandom();
    if (w.fields.exponent == 8'hff) begin
      w.fields.exponent = 8'hfe;  // Keeps it off inf and NaN.
    end
    return w;
  endfunction

  function automatic float_pkg::float_word_u random_nan();
    float_pkg::float_word_u w;
    w.raw = 32'h7f80_0001 | ($urandom() & 32'h807f_ffff);
    return w;
  endfunction

  // One lane in nan_one_in is a NaN; zero gives no NaNs.
  function automatic lanes_t random_lanes(int nan_one_in);
    lanes_t v;
    for (int i = 0; i < `ARGMIN_LANES; i++) begin
      if (nan_one_in > 0 && ($urandom() % nan_one_in) == 0) begin
        v[i] = random_nan();
      end else begin
        v[i] = random_finite();
      end
    end
    return v;
  endfunction

  function automatic lanes_t fill_lanes(logic [31:0] raw);
    lanes_t v;
    for (int i = 0; i < `ARGMIN_LANES; i++) begin
      v[i].raw = raw;
    end
    return v;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checking
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at time %0t while waiting for %s.", $time, what);
    timeout_count++;
  endtask

  // Index and value only mean something when a lane was found.
  task automatic compare_result(input argmin_pkg::argmin_result_t expected,
                                input argmin_pkg::argmin_result_t actual);
    check_value("m_axis_result_tdata.found", 32'(expected.found), 32'(actual.found));
    if (expected.found) begin
      check_value("m_axis_result_tdata.index", 32'(expected.index), 32'(actual.index));
      check_value("m_axis_result_tdata.value", expected.value.raw, actual.value.raw);
    end
  endtask

  // Sends one beat and waits for its result. Entered and left 1 ns after a
  // rising edge. Latency counts edges from input to output transfer.
  task automatic send_one(input lanes_t v, input tag_t t, output int latency,
                          output argmin_pkg::argmin_result_t got);
    argmin_pkg::argmin_result_t expected;
    int                         waited;
    expected  = model_argmin(v, t);
    lane_data = v;
    tag       = t;
    in_valid  = 1'b1;
    out_ready = 1'b1;
    waited    = 0;
    @(negedge aclk);
    while (!in_ready && waited < WAIT_LIMIT) begin
      @(posedge aclk);
      @(negedge aclk);
      waited++;
    end
    if (!in_ready) begin
      report_timeout("s_axis_a_tready");
    end
    @(posedge aclk);  // Input transfer edge.
    #1;
    in_valid = 1'b0;
    latency  = 0;
    @(negedge aclk);
    while (!out_valid && latency < WAIT_LIMIT) begin
      @(posedge aclk);
      latency++;
      @(negedge aclk);
    end
    if (!out_valid) begin
      report_timeout("m_axis_result_tvalid");
    end
    got     = result;
    latency = latency + 1;
    compare_result(expected, got);
    @(posedge aclk);
    #1;
  endtask

  task automatic send_expect_index(input lanes_t v, input tag_t t, input int lane);
    int                         latency;
    argmin_pkg::argmin_result_t got;
    send_one(v, t, latency, got);
    check_value("m_axis_result_tdata.index", lane, 32'(got.index));
  endtask

  // Feeds random beats while a monitor drains and checks results in order.
  task automatic run_stream(input int beats, input bit with_stalls);
    lanes_t v;
    tag_t   t;
    int     sent;
    int     received;
    int     in_stalls;
    int     gaps;
    int     stall_left;
    int     guard_in;
    int     guard_out;
    sent       = 0;
    received   = 0;
    in_stalls  = 0;
    gaps       = 0;
    stall_left = 0;
    guard_in   = 0;
    guard_out  = 0;
    expected_q.delete();
    v         = random_lanes(8);
    t         = tag_t'($urandom());
    out_ready = 1'b1;
    fork
      begin
        while (sent < beats && guard_in < STREAM_LIMIT) begin
          lane_data = v;
          tag       = t;
          in_valid  = 1'b1;
          @(negedge aclk);
          if (in_ready) begin
            expected_q.push_back(model_argmin(v, t));
            sent++;
            v = random_lanes(8);
            t = tag_t'($urandom());
          end else begin
            in_stalls++;
          end
          @(posedge aclk);
          #1;
          guard_in++;
        end
        in_valid = 1'b0;
        if (sent < beats) begin
          report_timeout("s_axis_a_tready during the stream");
        end
      end
      begin
        while (received < beats && guard_out < STREAM_LIMIT) begin
          @(negedge aclk);
          if (out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
              $display("A result at time %0t came with no beat outstanding.", $time);
              error_count++;
            end else begin
              compare_result(expected_q.pop_front(), result);
            end
            received++;
          end else if (received > 0 && !out_valid) begin
            gaps++;
          end
          @(posedge aclk);
          #1;
          guard_out++;
          if (with_stalls) begin
            if (stall_left > 0) begin
              stall_left--;
              out_ready = 1'b0;
            end else if (($urandom() % 4) == 0) begin
              stall_left = $urandom() % 6;  // Stretch of one to six cycles.
              out_ready  = 1'b0;
            end else begin
              out_ready = 1'b1;
            end
          end
        end
        out_ready = 1'b1;
        if (received < beats) begin
          report_timeout("m_axis_result_tvalid during the stream");
        end
      end
    join
    check_value("results still outstanding", 0, expected_q.size());
    if (with_stalls) begin
      if (in_stalls == 0) begin
        $display("s_axis_a_tready never fell while results were held back.");
        error_count++;
      end
    end else begin
      check_value("s_axis_a_tready low cycles", 0, in_stalls);
      check_value("m_axis_result_tvalid gap cycles", 0, gaps);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic reset_and_single_beat();
    int                         latency;
    argmin_pkg::argmin_result_t got;
    @(negedge aclk);
    check_value("m_axis_result_tvalid", 0, 32'(out_valid));
    check_value("s_axis_a_tready", 1, 32'(in_ready));
    @(posedge aclk);
    #1;
    send_one(random_lanes(0), ALL_TAGS, latency, got);
    check_value("result latency", 4, latency);
  endtask

  task automatic eligibility_cases();
    lanes_t                     v;
    tag_t                       t;
    int                         latency;
    argmin_pkg::argmin_result_t got;
    v = random_lanes(0);
    for (int i = 0; i < `ARGMIN_LANES; i++) begin
      v[i].raw[31] = 1'b0;
    end
    v[5].raw = 32'hc47a_0000;  // -1000.0 on an untagged lane.
    t        = ALL_TAGS;
    t[5]     = 1'b0;
    send_one(v, t, latency, got);
    v        = random_lanes(0);
    v[9].raw = 32'h7fc0_0000;
    t        = '0;
    t[9]     = 1'b1;
    send_expect_index(v, t, 9);
    send_one(random_lanes(4), '0, latency, got);
  endtask

  task automatic special_value_cases();
    lanes_t v;
    v         = fill_lanes(32'h3f80_0000);
    v[12].raw = 32'hbf00_0000;
    send_expect_index(v, ALL_TAGS, 12);
    v        = fill_lanes(32'h4000_0000);
    v[3].raw = 32'h8000_0000;
    v[7].raw = 32'h0000_0000;
    send_expect_index(v, ALL_TAGS, 3);
    v[3].raw = 32'h0000_0000;
    v[7].raw = 32'h8000_0000;
    send_expect_index(v, ALL_TAGS, 3);
    v         = fill_lanes(32'h40a0_0000);
    v[6].raw  = 32'hc040_0000;
    v[11].raw = 32'hc040_0000;
    send_expect_index(v, ALL_TAGS, 6);
    v         = fill_lanes(32'h7fc0_0000);
    v[2].raw  = 32'hffc0_0001;
    v[14].raw = 32'h7f80_0000;  // Infinity is still a number.
    send_expect_index(v, ALL_TAGS, 14);
  endtask

  initial begin
    error_count   = 0;
    timeout_count = 0;
    rst_n         = 1'b0;
    lane_data     = '0;
    tag           = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b1;
    void'($urandom(98));
    repeat (8) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    reset_and_single_beat();
    eligibility_cases();
    special_value_cases();
    run_stream(20, 1'b0);
    run_stream(60, 1'b1);
    $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/float_pkg.sv
logic/argmin_pkg.sv
logic/float_argmin.sv
logic/float_multi_argmin.sv
bench/tb_clock.sv
bench/tb_float_multi_argmin.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the argmin testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns \
  -f sources.f \
  --top-module tb_float_multi_argmin \
  -o sim_argmin

./obj_dir/sim_argmin | tee "$LOG"

if grep -qx "NO ERRORS" "$LOG"; then
  echo "Simulation passed."
else
  echo "Simulation failed, see $LOG."
  exit 1
fi
